// ==== design/disp_macros.svh ====
`ifndef DISP_MACROS_SVH
`define DISP_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Display timing

// Horizontal, in clocks
`define H_ACTIVE     32
`define H_FRONT      4
`define H_SYNC       4
`define H_BACK       4
`define H_TOTAL      44

// Vertical, in lines
`define V_ACTIVE     16
`define V_FRONT      2
`define V_SYNC       2
`define V_BACK       2
`define V_TOTAL      22

////////////////////////////////////////////////////////////////////////////
// Widths and reset values

`define PWM_BITS     7      // Backlight counter and duty width
`define PWM_RESET    8'd64  // Half duty, normal polarity
`define WIN_W_RESET  12'd16
`define WIN_H_RESET  12'd8

////////////////////////////////////////////////////////////////////////////
// Device command map

`define IDX_FLASH    8'h00
`define IDX_PWM      8'h01
`define IDX_WIN      8'h02
`define IDX_FRAME    8'h03  // Read only
`define CMD_WIN_W    8'h00  // Under IDX_WIN
`define CMD_WIN_H    8'h01

`endif

// ==== design/disp_pkg.sv ====
package disp_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Device command bus

	// Index or command byte
	typedef logic [7:0] dev_byte_t;

	// Write and read data
	typedef logic [31:0] dev_word_t;

	////////////////////////////////////////////////////////////////////////////
	// Display path

	// Pixel coordinate, also used for window size
	typedef logic [11:0] coord_t;

	// Backlight duty, 0 to 127
	typedef logic [6:0] pwm_duty_t;

	// One pixel, red on top
	typedef struct packed {
		logic [7:0] r;  // Bits 23..16
		logic [7:0] g;  // Bits 15..8
		logic [7:0] b;  // Bits 7..0
	} rgb_t;

	// Camera frames seen, wraps at 16
	typedef logic [3:0] frame_cnt_t;

endpackage

// ==== design/dev_cmd_regs.sv ====
`include "disp_macros.svh"

module dev_cmd_regs
	import disp_pkg::*;
(
	input  logic       clk_sys,
	input  logic       w_pll_lock,    // Async, active low
	input  dev_byte_t  dev_index_i,
	input  dev_byte_t  dev_cmd_i,
	input  dev_word_t  dev_wdata_i,
	input  logic       dev_wvalid_i,  // Single cycle write strobe
	input  logic       dev_rvalid_i,  // Single cycle read strobe
	input  frame_cnt_t frame_cnt_i,
	output dev_word_t  dev_rdata_o,
	output logic       flash_en_o,
	output pwm_duty_t  pwm_duty_o,
	output logic       pwm_pol_o,
	output coord_t     win_w_o,
	output coord_t     win_h_o
);

	// Address decode, shared by writes and reads
	logic       sel_flash;
	logic       sel_pwm;
	logic       sel_win_w;
	logic       sel_win_h;
	logic       sel_frame;
	logic [7:0] pwm_reg;         // [6:0] duty, [7] polarity
	coord_t     win_w_clamp;
	coord_t     win_h_clamp;
	dev_word_t  rd_mux;

	assign sel_flash = (dev_index_i == `IDX_FLASH) && (dev_cmd_i == 8'h00);
	assign sel_pwm   = (dev_index_i == `IDX_PWM)   && (dev_cmd_i == 8'h00);
	assign sel_win_w = (dev_index_i == `IDX_WIN)   && (dev_cmd_i == `CMD_WIN_W);
	assign sel_win_h = (dev_index_i == `IDX_WIN)   && (dev_cmd_i == `CMD_WIN_H);
	assign sel_frame = (dev_index_i == `IDX_FRAME) && (dev_cmd_i == 8'h00);

	// Window can never be larger than the active area
	// Full 32 bit compare so huge values clamp too
	assign win_w_clamp = (dev_wdata_i > `H_ACTIVE) ? coord_t'(`H_ACTIVE) : dev_wdata_i[11:0];
	assign win_h_clamp = (dev_wdata_i > `V_ACTIVE) ? coord_t'(`V_ACTIVE) : dev_wdata_i[11:0];

	////////////////////////////////////////////////////////////////////////////
	// Control registers

	always_ff @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			flash_en_o <= 1'b0;
			pwm_reg    <= `PWM_RESET;
			win_w_o    <= `WIN_W_RESET;
			win_h_o    <= `WIN_H_RESET;
		end else if (dev_wvalid_i) begin
			if (sel_flash)
				flash_en_o <= dev_wdata_i[0];    // Only bit 0 counts
			if (sel_pwm)
				pwm_reg <= dev_wdata_i[7:0];
			if (sel_win_w)
				win_w_o <= win_w_clamp;
			if (sel_win_h)
				win_h_o <= win_h_clamp;
		end
	end

	assign pwm_duty_o = pwm_reg[`PWM_BITS-1:0];
	assign pwm_pol_o  = pwm_reg[`PWM_BITS];

	////////////////////////////////////////////////////////////////////////////
	// Readback

	// Unmapped pairs fall through to zero
	always_comb begin
		rd_mux = '0;
		if (sel_flash)
			rd_mux = {31'd0, flash_en_o};
		else if (sel_pwm)
			rd_mux = {24'd0, pwm_reg};
		else if (sel_win_w)
			rd_mux = {20'd0, win_w_o};
		else if (sel_win_h)
			rd_mux = {20'd0, win_h_o};
		else if (sel_frame)
			rd_mux = {28'd0, frame_cnt_i};  // Live count, not latched
	end

	// Data shows one cycle after the strobe, then holds
	always_ff @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock)
			dev_rdata_o <= '0;
		else if (dev_rvalid_i)
			dev_rdata_o <= rd_mux;
	end

endmodule

// ==== design/pwm_lite.sv ====
`include "disp_macros.svh"

module pwm_lite
	import disp_pkg::*;
(
	input  logic      clk_sys,
	input  logic      w_pll_lock,
	input  pwm_duty_t duty_i,      // High cycles per 128
	input  logic      pol_i,       // 1 inverts the output
	output logic      pwm_o
);

	logic [`PWM_BITS-1:0] pwm_cnt;  // Free running, wraps at 128
	logic                 pwm_raw;

	always_ff @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock)
			pwm_cnt <= '0;
		else
			pwm_cnt <= pwm_cnt + 1'b1;
	end

	// Compare then flip on polarity
	assign pwm_raw = (pwm_cnt < duty_i) ^ pol_i;

	// Registered so the backlight pin is glitch free
	// One cycle late, duty per period unchanged
	always_ff @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock)
			pwm_o <= 1'b0;
		else
			pwm_o <= pwm_raw;
	end

endmodule

// ==== design/disp_timing_gen.sv ====
`include "disp_macros.svh"

module disp_timing_gen
	import disp_pkg::*;
(
	input  logic   clk_sys,
	input  logic   w_pll_lock,
	output logic   hs_o,       // Active high
	output logic   vs_o,       // Active high, whole lines
	output logic   de_o,
	output coord_t xpos_o,
	output coord_t ypos_o
);

	// Sync windows, start inclusive and end exclusive
	localparam int HS_START = `H_ACTIVE + `H_FRONT;
	localparam int HS_END   = HS_START + `H_SYNC;
	localparam int VS_START = `V_ACTIVE + `V_FRONT;
	localparam int VS_END   = VS_START + `V_SYNC;

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_last;   // Last clock of the line
	logic   v_last;   // Last line of the frame

	assign h_last = (h_cnt == coord_t'(`H_TOTAL - 1));
	assign v_last = (v_cnt == coord_t'(`V_TOTAL - 1));

	////////////////////////////////////////////////////////////////////////////
	// Counters

	always_ff @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last)
				h_cnt <= '0;
			else
				h_cnt <= h_cnt + 1'b1;

			// Line advance on horizontal wrap
			if (h_last) begin
				if (v_last)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Region decode

	// Straight off the counter registers, the output stage adds the flop
	assign de_o = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
	assign hs_o = (h_cnt >= HS_START) && (h_cnt < HS_END);
	assign vs_o = (v_cnt >= VS_START) && (v_cnt < VS_END);

	assign xpos_o = h_cnt;
	assign ypos_o = v_cnt;

endmodule

// ==== design/lcd_out_stage.sv ====
`include "disp_macros.svh"

module lcd_out_stage
	import disp_pkg::*;
(
	input  logic       clk_sys,
	input  logic       w_pll_lock,
	input  logic       hs_i,
	input  logic       vs_i,
	input  logic       de_i,
	input  coord_t     xpos_i,
	input  coord_t     ypos_i,
	input  coord_t     win_w_i,       // Clamped to H_ACTIVE upstream
	input  coord_t     win_h_i,       // Clamped to V_ACTIVE upstream
	input  logic       flash_en_i,    // Pins go to the SPI burner
	input  rgb_t       pixel_i,
	input  logic [3:0] spi_dq_i,
	input  logic [3:0] spi_dq_oe_i,
	output logic       hs_o,
	output logic       vs_o,
	output logic       de_o,
	output rgb_t       rgb_o,
	output rgb_t       rgb_oe_o
);

	localparam int X_MID = `H_ACTIVE / 2;
	localparam int Y_MID = `V_ACTIVE / 2;

	coord_t      half_w;
	coord_t      half_h;
	logic [12:0] x_sum;    // xpos plus half width
	logic [12:0] x_end;    // One past the right edge
	logic [12:0] y_sum;
	logic [12:0] y_end;
	logic        in_win;
	rgb_t        pix_mux;
	rgb_t        oe_mux;

	////////////////////////////////////////////////////////////////////////////
	// Centred window test

	assign half_w = win_w_i >> 1;
	assign half_h = win_h_i >> 1;

	// Left bound moved across, avoids underflow of MID - half
	assign x_sum = {1'b0, xpos_i} + {1'b0, half_w};
	assign x_end = 13'(X_MID) + {1'b0, half_w};
	assign y_sum = {1'b0, ypos_i} + {1'b0, half_h};
	assign y_end = 13'(Y_MID) + {1'b0, half_h};

	// Blanking coordinates always land outside
	assign in_win = (x_sum >= 13'(X_MID)) && ({1'b0, xpos_i} < x_end) &&
	                (y_sum >= 13'(Y_MID)) && ({1'b0, ypos_i} < y_end);

	////////////////////////////////////////////////////////////////////////////
	// Pin mux

	always_comb begin
		if (flash_en_i) begin
			// Quad SPI lanes on G[1:0] and B[3:2]
			pix_mux.r = 8'h00;
			pix_mux.g = {6'd0, spi_dq_i[1:0]};
			pix_mux.b = {4'd0, spi_dq_i[3:2], 2'd0};
			oe_mux.r  = 8'h00;
			oe_mux.g  = {6'd0, spi_dq_oe_i[1:0]};
			oe_mux.b  = {4'd0, spi_dq_oe_i[3:2], 2'd0};
		end else begin
			pix_mux = in_win ? pixel_i : '0;  // Black outside
			oe_mux  = '1;                     // Panel drives all pins
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register, one cycle

	always_ff @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			hs_o     <= 1'b0;
			vs_o     <= 1'b0;
			de_o     <= 1'b0;
			rgb_o    <= '0;
			rgb_oe_o <= '1;    // Normal mode pins
		end else begin
			hs_o     <= hs_i;
			vs_o     <= vs_i;
			de_o     <= de_i;
			rgb_o    <= pix_mux;
			rgb_oe_o <= oe_mux;
		end
	end

endmodule

// ==== design/vsync_frame_counter.sv ====
`include "disp_macros.svh"

module vsync_frame_counter
	import disp_pkg::*;
(
	input  logic       clk_sys,
	input  logic       w_pll_lock,
	input  logic       vsync_i,      // Camera vsync, slow level
	output frame_cnt_t frame_cnt_o
);

	logic [1:0] vs_hist;   // [0] newest sample
	logic       vs_rise;

	// Older low, newer high
	assign vs_rise = (vs_hist == 2'b01);

	always_ff @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			vs_hist     <= 2'b00;
			frame_cnt_o <= '0;
		end else begin
			vs_hist <= {vs_hist[0], vsync_i};
			if (vs_rise)
				frame_cnt_o <= frame_cnt_o + 1'b1;  // Wraps at 16
		end
	end

endmodule

// ==== design/disp_top.sv ====
`include "disp_macros.svh"

module disp_top
	import disp_pkg::*;
(
	input  logic       clk_sys,
	input  logic       w_pll_lock,     // PLL lock, async reset for all
	input  dev_byte_t  dev_index_i,
	input  dev_byte_t  dev_cmd_i,
	input  dev_word_t  dev_wdata_i,
	input  logic       dev_wvalid_i,
	input  logic       dev_rvalid_i,
	input  rgb_t       pixel_i,        // Pixel for the current coordinate
	input  logic [3:0] spi_dq_i,
	input  logic [3:0] spi_dq_oe_i,
	input  logic       cmos_vsync_i,
	output dev_word_t  dev_rdata_o,
	output logic       de_o,
	output logic       hs_o,
	output logic       vs_o,
	output rgb_t       rgb_o,
	output rgb_t       rgb_oe_o,
	output logic       pwm_o,          // Panel backlight
	output logic       led_frame_o
);

	logic       flash_en;
	pwm_duty_t  pwm_duty;
	logic       pwm_pol;
	coord_t     win_w;
	coord_t     win_h;
	frame_cnt_t frame_cnt;
	logic       tg_hs;
	logic       tg_vs;
	logic       tg_de;
	coord_t     tg_xpos;
	coord_t     tg_ypos;

	////////////////////////////////////////////////////////////////////////////
	// Device registers and backlight

	dev_cmd_regs u_dev_cmd_regs (
		.clk_sys      (clk_sys),
		.w_pll_lock   (w_pll_lock),
		.dev_index_i  (dev_index_i),
		.dev_cmd_i    (dev_cmd_i),
		.dev_wdata_i  (dev_wdata_i),
		.dev_wvalid_i (dev_wvalid_i),
		.dev_rvalid_i (dev_rvalid_i),
		.frame_cnt_i  (frame_cnt),
		.dev_rdata_o  (dev_rdata_o),
		.flash_en_o   (flash_en),
		.pwm_duty_o   (pwm_duty),
		.pwm_pol_o    (pwm_pol),
		.win_w_o      (win_w),
		.win_h_o      (win_h)
	);

	pwm_lite u_pwm_lite (
		.clk_sys    (clk_sys),
		.w_pll_lock (w_pll_lock),
		.duty_i     (pwm_duty),
		.pol_i      (pwm_pol),
		.pwm_o      (pwm_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// LCD path

	disp_timing_gen u_disp_timing_gen (
		.clk_sys    (clk_sys),
		.w_pll_lock (w_pll_lock),
		.hs_o       (tg_hs),
		.vs_o       (tg_vs),
		.de_o       (tg_de),
		.xpos_o     (tg_xpos),
		.ypos_o     (tg_ypos)
	);

	lcd_out_stage u_lcd_out_stage (
		.clk_sys     (clk_sys),
		.w_pll_lock  (w_pll_lock),
		.hs_i        (tg_hs),
		.vs_i        (tg_vs),
		.de_i        (tg_de),
		.xpos_i      (tg_xpos),
		.ypos_i      (tg_ypos),
		.win_w_i     (win_w),
		.win_h_i     (win_h),
		.flash_en_i  (flash_en),
		.pixel_i     (pixel_i),
		.spi_dq_i    (spi_dq_i),
		.spi_dq_oe_i (spi_dq_oe_i),
		.hs_o        (hs_o),
		.vs_o        (vs_o),
		.de_o        (de_o),
		.rgb_o       (rgb_o),
		.rgb_oe_o    (rgb_oe_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Camera frame LED

	vsync_frame_counter u_vsync_frame_counter (
		.clk_sys     (clk_sys),
		.w_pll_lock  (w_pll_lock),
		.vsync_i     (cmos_vsync_i),
		.frame_cnt_o (frame_cnt)
	);

	assign led_frame_o = frame_cnt[3];  // Toggles every 8 frames

endmodule

// ==== dv/disp_tb.sv ====
`include "disp_macros.svh"

module disp_tb
	import disp_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYC  = `H_TOTAL * `V_TOTAL;       // Clocks per frame
	localparam int TIMEOUT_NS = 12 * FRAME_CYC * 20 + 5000;

	logic       clk_sys = 1'b0;
	logic       w_pll_lock;
	dev_byte_t  dev_index_i;
	dev_byte_t  dev_cmd_i;
	dev_word_t  dev_wdata_i;
	logic       dev_wvalid_i;
	logic       dev_rvalid_i;
	rgb_t       pixel_i;
	logic [3:0] spi_dq_i;
	logic [3:0] spi_dq_oe_i;
	logic       cmos_vsync_i;
	dev_word_t  dev_rdata_o;
	logic       de_o;
	logic       hs_o;
	logic       vs_o;
	rgb_t       rgb_o;
	rgb_t       rgb_oe_o;
	logic       pwm_o;
	logic       led_frame_o;

	// Reference model state
	int         m_h;
	int         m_v;
	int         exp_x;          // Coordinate seen at the outputs
	int         exp_y;
	logic       exp_de;
	logic       exp_hs;
	logic       exp_vs;
	rgb_t       prev_pix;       // Inputs one cycle back
	logic [3:0] prev_dq;
	logic [3:0] prev_oe;
	rgb_t       exp_rgb_win;
	rgb_t       exp_rgb_flash;
	rgb_t       exp_oe_flash;
	int         win_w_sh = `WIN_W_RESET;   // Window size the DUT should hold
	int         win_h_sh = `WIN_H_RESET;
	logic       chk_win   = 1'b0;
	logic       chk_flash = 1'b0;
	int         err_cnt   = 0;
	int         test_cnt  = 0;
	int         pass_cnt  = 0;

	always #10 clk_sys = ~clk_sys;

	disp_top uut (
		.clk_sys      (clk_sys),
		.w_pll_lock   (w_pll_lock),
		.dev_index_i  (dev_index_i),
		.dev_cmd_i    (dev_cmd_i),
		.dev_wdata_i  (dev_wdata_i),
		.dev_wvalid_i (dev_wvalid_i),
		.dev_rvalid_i (dev_rvalid_i),
		.pixel_i      (pixel_i),
		.spi_dq_i     (spi_dq_i),
		.spi_dq_oe_i  (spi_dq_oe_i),
		.cmos_vsync_i (cmos_vsync_i),
		.dev_rdata_o  (dev_rdata_o),
		.de_o         (de_o),
		.hs_o         (hs_o),
		.vs_o         (vs_o),
		.rgb_o        (rgb_o),
		.rgb_oe_o     (rgb_oe_o),
		.pwm_o        (pwm_o),
		.led_frame_o  (led_frame_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	// Centred window bounds, both ends inclusive
	function automatic bit in_window(int x, int y, int w, int h);
		int x_lo;
		int x_hi;
		int y_lo;
		int y_hi;
		x_lo = `H_ACTIVE / 2 - w / 2;
		x_hi = `H_ACTIVE / 2 + w / 2 - 1;
		y_lo = `V_ACTIVE / 2 - h / 2;
		y_hi = `V_ACTIVE / 2 + h / 2 - 1;
		return (x >= x_lo) && (x <= x_hi) && (y >= y_lo) && (y <= y_hi);
	endfunction

	// SPI lanes placed on G[1:0] and B[3:2]
	function automatic rgb_t flash_pins(logic [3:0] lanes);
		rgb_t pins;
		pins      = '0;
		pins.g[1:0] = lanes[1:0];
		pins.b[3:2] = lanes[3:2];
		return pins;
	endfunction

	always @(posedge clk_sys or negedge w_pll_lock) begin
		if (!w_pll_lock) begin
			m_h      <= 0;
			m_v      <= 0;
			exp_x    <= -1;    // Nothing valid yet
			exp_y    <= -1;
			exp_de   <= 1'b0;
			exp_hs   <= 1'b0;
			exp_vs   <= 1'b0;
			prev_pix <= '0;
			prev_dq  <= '0;
			prev_oe  <= '0;
		end else begin
			// Predictions land one clock later like the output flop
			exp_de   <= (m_h < `H_ACTIVE) && (m_v < `V_ACTIVE);
			exp_hs   <= (m_h >= `H_ACTIVE + `H_FRONT) &&
			            (m_h < `H_ACTIVE + `H_FRONT + `H_SYNC);
			exp_vs   <= (m_v >= `V_ACTIVE + `V_FRONT) &&
			            (m_v < `V_ACTIVE + `V_FRONT + `V_SYNC);
			exp_x    <= m_h;
			exp_y    <= m_v;
			prev_pix <= pixel_i;
			prev_dq  <= spi_dq_i;
			prev_oe  <= spi_dq_oe_i;
			if (m_h == `H_TOTAL - 1) begin
				m_h <= 0;
				m_v <= (m_v == `V_TOTAL - 1) ? 0 : m_v + 1;   // Frame wrap
			end else begin
				m_h <= m_h + 1;
			end
		end
	end

	always_comb exp_rgb_win   = in_window(exp_x, exp_y, win_w_sh, win_h_sh) ? prev_pix : '0;
	always_comb exp_rgb_flash = flash_pins(prev_dq);
	always_comb exp_oe_flash  = flash_pins(prev_oe);

	////////////////////////////////////////////////////////////////////////////
	// Cycle checks

	sync_match: assert property (@(negedge clk_sys) disable iff (!w_pll_lock)
		(de_o == exp_de) && (hs_o == exp_hs) && (vs_o == exp_vs))
		else begin
			err_cnt++;
			$display("mismatch at %0t: de/hs/vs %b%b%b, model %b%b%b",
			         $time, de_o, hs_o, vs_o, exp_de, exp_hs, exp_vs);
		end

	window_match: assert property (@(negedge clk_sys)
		chk_win |-> (rgb_o == exp_rgb_win) && (rgb_oe_o == 24'hFF_FFFF))
		else begin
			err_cnt++;
			$display("mismatch at %0t: window (%0d,%0d) rgb %h oe %h, expected %h",
			         $time, exp_x, exp_y, rgb_o, rgb_oe_o, exp_rgb_win);
		end

	flash_match: assert property (@(negedge clk_sys)
		chk_flash |-> (rgb_o == exp_rgb_flash) && (rgb_oe_o == exp_oe_flash))
		else begin
			err_cnt++;
			$display("mismatch at %0t: flash rgb %h oe %h, expected %h %h",
			         $time, rgb_o, rgb_oe_o, exp_rgb_flash, exp_oe_flash);
		end

	// Fresh pixel and lane values every clock once out of reset
	always @(negedge clk_sys) begin
		if (w_pll_lock) begin
			pixel_i     <= rgb_t'(24'($urandom));
			spi_dq_i    <= 4'($urandom);
			spi_dq_oe_i <= 4'($urandom);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus and measurement tasks

	task automatic reg_write(input dev_byte_t idx, input dev_byte_t cmd, input dev_word_t data);
		@(negedge clk_sys);
		dev_index_i  = idx;
		dev_cmd_i    = cmd;
		dev_wdata_i  = data;
		dev_wvalid_i = 1'b1;
		@(negedge clk_sys);
		dev_wvalid_i = 1'b0;
	endtask

	// Read data is loaded on the strobe edge
	task automatic check_read(input dev_byte_t idx, input dev_byte_t cmd,
	                          input dev_word_t exp_val, input string what);
		dev_word_t got;
		@(negedge clk_sys);
		dev_index_i  = idx;
		dev_cmd_i    = cmd;
		dev_rvalid_i = 1'b1;
		@(negedge clk_sys);
		dev_rvalid_i = 1'b0;
		got          = dev_rdata_o;
		assert (got == exp_val)
		else begin
			err_cnt++;
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp_val);
		end
	endtask

	// Clamp follows the register map rule
	task automatic set_window(input int w, input int h);
		reg_write(`IDX_WIN, `CMD_WIN_W, dev_word_t'(w));
		reg_write(`IDX_WIN, `CMD_WIN_H, dev_word_t'(h));
		win_w_sh = (w > `H_ACTIVE) ? `H_ACTIVE : w;
		win_h_sh = (h > `V_ACTIVE) ? `V_ACTIVE : h;
	endtask

	task automatic check_pwm(input int exp_high);
		int n;
		n = 0;
		repeat (128) begin
			@(negedge clk_sys);
			if (pwm_o)
				n++;
		end
		assert (n == exp_high)
		else begin
			err_cnt++;
			$display("mismatch at %0t: pwm high %0d of 128, expected %0d", $time, n, exp_high);
		end
	endtask

	task automatic close_test(input string name, input int errs_at_start);
		test_cnt++;
		if (err_cnt == errs_at_start) begin
			pass_cnt++;
			$display("test %-14s ok", name);
		end else begin
			$display("test %-14s failed with %0d errors", name, err_cnt - errs_at_start);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int errs;
		int duty;
		int pol;
		int de_cnt;
		int hs_rise;
		int vs_run;
		int vs_best;
		logic hs_prev;
		int pulses;
		void'($urandom(13579));
		w_pll_lock   = 1'b0;
		dev_index_i  = '0;
		dev_cmd_i    = '0;
		dev_wdata_i  = '0;
		dev_wvalid_i = 1'b0;
		dev_rvalid_i = 1'b0;
		pixel_i      = '0;
		spi_dq_i     = '0;
		spi_dq_oe_i  = '0;
		cmos_vsync_i = 1'b0;
		repeat (10) @(negedge clk_sys);
		errs = err_cnt;
		assert ((rgb_o == '0) && !de_o && !hs_o && !vs_o)
		else begin
			err_cnt++;
			$display("mismatch at %0t: outputs not quiet while reset is held", $time);
		end
		w_pll_lock = 1'b1;    // Released on a falling edge

		// Reset values
		assert (rgb_oe_o == 24'hFF_FFFF)
		else begin
			err_cnt++;
			$display("mismatch at %0t: rgb_oe %h after reset", $time, rgb_oe_o);
		end
		check_pwm(64);
		check_read(`IDX_PWM, 8'h00, dev_word_t'(`PWM_RESET), "pwm reset");
		check_read(`IDX_WIN, `CMD_WIN_W, dev_word_t'(`WIN_W_RESET), "width reset");
		check_read(`IDX_WIN, `CMD_WIN_H, dev_word_t'(`WIN_H_RESET), "height reset");
		check_read(`IDX_FLASH, 8'h00, 32'd0, "flash reset");
		close_test("reset_values", errs);

		// Writes and readback
		errs = err_cnt;
		duty = $urandom % 128;
		pol  = $urandom % 2;
		reg_write(`IDX_PWM, 8'h00, dev_word_t'(pol * 128 + duty));
		check_read(`IDX_PWM, 8'h00, dev_word_t'(pol * 128 + duty), "pwm");
		check_pwm(pol ? 128 - duty : duty);
		set_window(100, 40);    // Both above the active area
		check_read(`IDX_WIN, `CMD_WIN_W, dev_word_t'(`H_ACTIVE), "width clamp");
		check_read(`IDX_WIN, `CMD_WIN_H, dev_word_t'(`V_ACTIVE), "height clamp");
		close_test("registers", errs);

		// One full frame from the top left pixel
		errs    = err_cnt;
		de_cnt  = 0;
		hs_rise = 0;
		vs_run  = 0;
		vs_best = 0;
		hs_prev = 1'b0;
		do
			@(negedge clk_sys);
		while (!(exp_x == 0 && exp_y == 0));
		repeat (FRAME_CYC) begin
			if (de_o)
				de_cnt++;
			if (hs_o && !hs_prev)
				hs_rise++;
			hs_prev = hs_o;
			vs_run  = vs_o ? vs_run + 1 : 0;
			if (vs_run > vs_best)
				vs_best = vs_run;
			@(negedge clk_sys);
		end
		assert ((de_cnt == `H_ACTIVE * `V_ACTIVE) && (hs_rise == `V_TOTAL) &&
		        (vs_best == `V_SYNC * `H_TOTAL))
		else begin
			err_cnt++;
			$display("mismatch at %0t: frame de %0d hs rises %0d vs run %0d",
			         $time, de_cnt, hs_rise, vs_best);
		end
		close_test("frame_timing", errs);

		// Random even window
		errs = err_cnt;
		set_window(2 * (1 + $urandom % 16), 2 * (1 + $urandom % 8));
		@(negedge clk_sys);     // New size reaches the output flop
		chk_win = 1'b1;
		repeat (FRAME_CYC) @(negedge clk_sys);
		chk_win = 1'b0;
		close_test("window", errs);

		// Flash burner owns the pins
		errs = err_cnt;
		reg_write(`IDX_FLASH, 8'h00, 32'd1);
		@(negedge clk_sys);
		chk_flash = 1'b1;
		repeat (200) @(negedge clk_sys);
		chk_flash = 1'b0;
		reg_write(`IDX_FLASH, 8'h00, 32'd0);
		@(negedge clk_sys);
		chk_win = 1'b1;         // Back to normal mode
		repeat (200) @(negedge clk_sys);
		chk_win = 1'b0;
		close_test("flash_mux", errs);

		// Camera vsync pulses
		errs   = err_cnt;
		pulses = 1 + $urandom % 20;
		repeat (pulses) begin
			@(negedge clk_sys);
			cmos_vsync_i = 1'b1;
			repeat (3 + $urandom % 4) @(negedge clk_sys);
			cmos_vsync_i = 1'b0;
			repeat (3 + $urandom % 4) @(negedge clk_sys);
		end
		check_read(`IDX_FRAME, 8'h00, dev_word_t'(pulses % 16), "frame count");
		assert (led_frame_o == 1'((pulses % 16) >> 3))
		else begin
			err_cnt++;
			$display("mismatch at %0t: led %b after %0d pulses", $time, led_frame_o, pulses);
		end
		close_test("frame_counter", errs);

		$display("summary: %0d of %0d tests clean, %0d errors", pass_cnt, test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Run limit well above the sum of all tests
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+design
design/disp_pkg.sv
design/dev_cmd_regs.sv
design/pwm_lite.sv
design/disp_timing_gen.sv
design/lcd_out_stage.sv
design/vsync_frame_counter.sv
design/disp_top.sv
dv/disp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the display testbench with Verilator
set -u -o pipefail

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module disp_tb -o disp_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/disp_sim 2>&1 | tee "$LOG"
if [ $? -ne 0 ]; then
	echo "simulation exited with an error"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0
